//--- hdl/dsi_macros.svh
`ifndef DSI_MACROS_SVH
`define DSI_MACROS_SVH

// DSI data types used by the video path
`define DSI_DT_VSS          6'h01
`define DSI_DT_HSS          6'h21
`define DSI_DT_BLANKING     6'h19
`define DSI_DT_PPS24        6'h3E

// payload byte of blanking packets
`define DSI_BLANK_BYTE      8'h55

// reflected CCITT CRC-16 with the low byte sent first
`define DSI_CRC_INIT        16'hFFFF
`define DSI_CRC_POLY        16'h8408

`define DSI_MAX_LANES       4
`define DSI_HDR_QUEUE_DEPTH 4

// header plus checksum of a long packet, in bytes
`define DSI_PKT_OVERHEAD    16'd6

`endif

//--- hdl/dsi_pkg.sv
`default_nettype none

package dsi_pkg;

    typedef struct packed {
        logic [1:0] vc;                 // virtual channel
        logic [5:0] dt;                 // data type
    } dsi_data_id_t;

    // one header word read as a long or a short packet
    typedef union packed {
        struct packed {
            logic [15:0]  word_count;   // payload bytes
            dsi_data_id_t data_id;
        } long_view;
        struct packed {
            logic [7:0]   data1;
            logic [7:0]   data0;
            dsi_data_id_t data_id;
        } short_view;
    } dsi_header_u;

    typedef struct packed {
        logic [15:0] line_bytes;        // bytes in one line
        logic [15:0] hbp_bytes;         // back porch blanking word count
        logic [15:0] hfp_bytes;         // front porch blanking word count
        logic [15:0] pixels;            // pixels per active line
        logic [15:0] vbp_lines;
        logic [15:0] active_lines;
        logic [15:0] vfp_lines;
    } video_timing_t;

    typedef struct packed {
        logic [31:0] data;              // first stream byte in 7:0
        logic [2:0]  nbytes;            // 1 to 4
    } lane_word_t;

endpackage

`default_nettype wire

//--- hdl/packet_ecc.sv
`timescale 1ns/1ps
`default_nettype none

module packet_ecc (
    input  wire dsi_pkg::dsi_header_u header,
    output logic [7:0]               ecc
);

    // header bits covered by each parity bit P0..P5
    localparam logic [23:0] PARITY_MASK [6] = '{
        24'hF12CB7,
        24'hF2555B,
        24'h749A6D,
        24'hB8E38E,
        24'hDF03F0,
        24'hEFFC00
    };

    always_comb
    begin
        ecc = 8'h00;                                             // bits 7:6 stay zero
        for (int i = 0; i < 6; i++)
        begin
            ecc[i] = ^(header & PARITY_MASK[i]);
        end
    end

endmodule

`default_nettype wire

//--- hdl/packet_crc.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsi_macros.svh"

module packet_crc (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 clear,
    input  wire                 update,
    input  wire dsi_pkg::lane_word_t word,
    output logic [15:0]         crc
);

    logic [15:0] crc_next;
    logic        fb;

    // LSB first over the valid bytes of the word
    always_comb
    begin
        crc_next = crc;
        fb       = 1'b0;
        for (int i = 0; i < 32; i++)
        begin
            if (i < 8 * int'(word.nbytes))
            begin
                fb       = crc_next[0] ^ word.data[i];
                crc_next = {1'b0, crc_next[15:1]} ^ ({16{fb}} & `DSI_CRC_POLY);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= `DSI_CRC_INIT;
        else if (clear)
            crc <= `DSI_CRC_INIT;                                // new packet
        else if (update)
            crc <= crc_next;
    end

endmodule

`default_nettype wire

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsi_macros.svh"

module frame_sequencer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    streaming_enable,
    input  wire dsi_pkg::video_timing_t timing,
    input  wire                    hdr_full,
    output logic                   hdr_write,
    output dsi_pkg::dsi_header_u   hdr_in
);

    localparam logic [3:0] ST_IDLE      = 4'd0;
    localparam logic [3:0] ST_VSS       = 4'd1;
    localparam logic [3:0] ST_VSS_BL    = 4'd2;
    localparam logic [3:0] ST_HSS_BACK  = 4'd3;
    localparam logic [3:0] ST_BACK_BL   = 4'd4;
    localparam logic [3:0] ST_HSS_ACT   = 4'd5;
    localparam logic [3:0] ST_HBP       = 4'd6;
    localparam logic [3:0] ST_RGB       = 4'd7;
    localparam logic [3:0] ST_HFP       = 4'd8;
    localparam logic [3:0] ST_HSS_FRONT = 4'd9;
    localparam logic [3:0] ST_FRONT_BL  = 4'd10;

    logic [3:0]  state;
    logic [3:0]  state_next;
    logic [3:0]  after_write;
    logic [3:0]  back_next;
    logic [3:0]  front_next;
    logic [15:0] vbp_cnt;
    logic [15:0] act_cnt;
    logic [15:0] vfp_cnt;
    logic [15:0] line_blank_wc;

    // whole line minus the sync packet and the blanking overhead
    assign line_blank_wc = timing.line_bytes - 16'd4 - `DSI_PKT_OVERHEAD;

    assign front_next = (vfp_cnt != 16'd0) ? ST_HSS_FRONT :
                        (streaming_enable ? ST_VSS : ST_IDLE);   // end of frame
    assign back_next  = (vbp_cnt != 16'd0) ? ST_HSS_BACK :
                        ((act_cnt != 16'd0) ? ST_HSS_ACT : front_next);

    assign hdr_write  = (state != ST_IDLE) && !hdr_full;         // one header per state
    assign state_next = (state == ST_IDLE || hdr_write) ? after_write : state;

    always_comb
    begin
        case (state)
            ST_IDLE:      after_write = streaming_enable ? ST_VSS : ST_IDLE;
            ST_VSS:       after_write = ST_VSS_BL;
            ST_VSS_BL,
            ST_BACK_BL:   after_write = back_next;
            ST_HSS_BACK:  after_write = ST_BACK_BL;
            ST_HSS_ACT:   after_write = ST_HBP;
            ST_HBP:       after_write = ST_RGB;
            ST_RGB:       after_write = ST_HFP;
            ST_HFP:       after_write = (act_cnt != 16'd0) ? ST_HSS_ACT : front_next;
            ST_HSS_FRONT: after_write = ST_FRONT_BL;
            ST_FRONT_BL:  after_write = front_next;
            default:      after_write = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // line counters count the lines still to start in each region
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vbp_cnt <= '0;
            act_cnt <= '0;
            vfp_cnt <= '0;
        end
        else if (state_next == ST_VSS)
        begin
            vbp_cnt <= timing.vbp_lines;
            act_cnt <= timing.active_lines;
            vfp_cnt <= timing.vfp_lines;
        end
        else if (hdr_write)
        begin
            if (state_next == ST_HSS_BACK)
                vbp_cnt <= vbp_cnt - 16'd1;
            if (state_next == ST_HSS_ACT)
                act_cnt <= act_cnt - 16'd1;
            if (state_next == ST_HSS_FRONT)
                vfp_cnt <= vfp_cnt - 16'd1;
        end
    end

    always_comb
    begin
        hdr_in = '0;                                             // vc stays 0
        case (state)
            ST_VSS, ST_HSS_BACK, ST_HSS_ACT, ST_HSS_FRONT:
            begin
                hdr_in.short_view.data_id.dt = (state == ST_VSS) ? `DSI_DT_VSS : `DSI_DT_HSS;
                hdr_in.short_view.data1      = 8'h00;
                hdr_in.short_view.data0      = 8'h00;
            end
            ST_VSS_BL, ST_BACK_BL, ST_FRONT_BL:
            begin
                hdr_in.long_view.data_id.dt = `DSI_DT_BLANKING;
                hdr_in.long_view.word_count = line_blank_wc;
            end
            ST_HBP, ST_HFP:
            begin
                hdr_in.long_view.data_id.dt = `DSI_DT_BLANKING;
                hdr_in.long_view.word_count = (state == ST_HBP) ? timing.hbp_bytes :
                                                                  timing.hfp_bytes;
            end
            ST_RGB:
            begin
                hdr_in.long_view.data_id.dt = `DSI_DT_PPS24;
                hdr_in.long_view.word_count = timing.pixels * 16'd3;   // 3 bytes per pixel
            end
            default:
                hdr_in = '0;
        endcase
    end

    // timing fields feed the word counts and hold while streaming
    a_timing_stable: assert property (@(posedge clk) disable iff (!rst_n)
        state != ST_IDLE |=> $stable(timing));

endmodule

`default_nettype wire

//--- hdl/header_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsi_macros.svh"

module header_queue (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  hdr_write,
    input  wire dsi_pkg::dsi_header_u hdr_in,
    input  wire                  hdr_read,
    output dsi_pkg::dsi_header_u hdr_out,
    output logic                 hdr_full,
    output logic                 hdr_empty
);

    localparam int DEPTH = `DSI_HDR_QUEUE_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    dsi_pkg::dsi_header_u mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   fill;
    logic          do_write;
    logic          do_read;

    assign do_write  = hdr_write && !hdr_full;
    assign do_read   = hdr_read && !hdr_empty;
    assign hdr_full  = (fill == (PW+1)'(DEPTH));
    assign hdr_empty = (fill == '0);
    assign hdr_out   = mem[rd_ptr];                              // head of queue

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= hdr_in;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;                         // wraps at depth
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + do_write - do_read;
        end
    end

    // the serializer only pops a header it has seen
    a_no_empty_read: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_read |-> !hdr_empty);

endmodule

`default_nettype wire

//--- hdl/packet_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsi_macros.svh"

module packet_serializer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire dsi_pkg::dsi_header_u hdr_out,
    input  wire                  hdr_empty,
    output logic                 hdr_read,
    input  wire [31:0]           pix_data,
    input  wire                  pix_empty,
    output logic                 pix_read,
    input  wire                  word_take,
    output logic                 word_valid,
    output dsi_pkg::lane_word_t  word
);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_HEADER = 3'd1;
    localparam logic [2:0] ST_PIX    = 3'd2;
    localparam logic [2:0] ST_BLANK  = 3'd3;
    localparam logic [2:0] ST_CRC    = 3'd4;

    logic [2:0]          state;
    logic [2:0]          state_next;
    logic [2:0]          pkt_end_next;
    logic [15:0]         bytes_left;
    logic [2:0]          chunk;
    logic                last_chunk;
    logic                hdr_long;
    logic                src_ready;
    logic                slot_free;
    logic                word_load;
    logic                crc_clear;
    logic                crc_update;
    logic [7:0]          ecc;
    logic [15:0]         crc;
    dsi_pkg::lane_word_t word_d;

    packet_ecc ecc_i (
        .header (hdr_out),
        .ecc    (ecc)
    );

    packet_crc crc_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (crc_clear),
        .update (crc_update),
        .word   (word_d),
        .crc    (crc)
    );

    assign hdr_long   = hdr_out.long_view.data_id.dt[3];         // long types have bit 3 set
    assign last_chunk = (bytes_left <= 16'd4);
    assign chunk      = last_chunk ? bytes_left[2:0] : 3'd4;
    assign slot_free  = !word_valid || word_take;
    assign word_load  = slot_free && src_ready;
    assign hdr_read   = word_load && (state == ST_HEADER);
    assign pix_read   = word_load && (state == ST_PIX);
    assign crc_clear  = hdr_read;
    assign crc_update = word_load && (state == ST_PIX || state == ST_BLANK);
    assign pkt_end_next = hdr_empty ? ST_IDLE : ST_HEADER;

    always_comb
    begin
        case (state)
            ST_HEADER:        src_ready = !hdr_empty;
            ST_PIX:           src_ready = !pix_empty;
            ST_BLANK, ST_CRC: src_ready = 1'b1;
            default:          src_ready = 1'b0;
        endcase
    end

    always_comb
    begin
        word_d = '0;
        case (state)
            ST_HEADER:
            begin
                word_d.data   = {ecc, hdr_out};
                word_d.nbytes = 3'd4;
            end
            ST_PIX:
            begin
                word_d.data   = pix_data;                        // low bytes on a short last word
                word_d.nbytes = chunk;
            end
            ST_BLANK:
            begin
                word_d.data   = {4{`DSI_BLANK_BYTE}};
                word_d.nbytes = chunk;
            end
            ST_CRC:
            begin
                word_d.data   = {16'h0000, crc};                 // low byte first
                word_d.nbytes = 3'd2;
            end
            default:
                word_d = '0;
        endcase
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
                state_next = hdr_empty ? ST_IDLE : ST_HEADER;
            ST_HEADER:
                if (word_load)
                begin
                    if (!hdr_long)
                        state_next = pkt_end_next;
                    else if (hdr_out.long_view.word_count == 16'd0)
                        state_next = ST_CRC;
                    else if (hdr_out.long_view.data_id.dt == `DSI_DT_PPS24)
                        state_next = ST_PIX;
                    else
                        state_next = ST_BLANK;
                end
            ST_PIX, ST_BLANK:
                if (word_load && last_chunk)
                    state_next = ST_CRC;
            ST_CRC:
                if (word_load)
                    state_next = pkt_end_next;
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= ST_IDLE;
            word_valid <= 1'b0;
            bytes_left <= '0;
        end
        else
        begin
            state <= state_next;
            if (word_load)
                word_valid <= 1'b1;
            else if (word_take)
                word_valid <= 1'b0;
            if (hdr_read)
                bytes_left <= hdr_out.long_view.word_count;
            else if (crc_update)
                bytes_left <= last_chunk ? 16'd0 : bytes_left - 16'd4;
        end
    end

    always_ff @(posedge clk)
    begin
        if (word_load)
            word <= word_d;
    end

    // payload states always have bytes left to send
    a_payload_left: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_PIX || state == ST_BLANK) |-> bytes_left != 16'd0);

endmodule

`default_nettype wire

//--- hdl/lane_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsi_macros.svh"

module lane_packer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [2:0]           lanes_number,
    input  wire                 word_valid,
    input  wire dsi_pkg::lane_word_t word,
    output logic                word_take,
    input  wire [3:0]           lanes_full,
    output logic [31:0]         lanes_data,
    output logic [3:0]          lanes_write
);

    localparam int SR_BYTES = 2 * `DSI_MAX_LANES;

    logic [8*SR_BYTES-1:0] sr_q;
    logic [8*SR_BYTES-1:0] sr_d;
    logic [3:0]            cnt_q;
    logic [3:0]            cnt_d;
    logic [3:0]            lanes;
    logic [3:0]            out_n;
    logic [3:0]            leaving;
    logic [3:0]            rem;
    logic                  beat_ok;
    logic                  beat;
    logic                  load;

    assign lanes   = {1'b0, lanes_number};
    assign out_n   = (cnt_q >= lanes) ? lanes : cnt_q;
    // partial beat only when nothing more is offered
    assign beat_ok = (cnt_q >= lanes) || (cnt_q != 4'd0 && !word_valid);
    assign beat    = beat_ok && !(|lanes_full);                  // any full lane stalls all
    assign leaving = beat ? out_n : 4'd0;
    assign rem     = cnt_q - leaving;

    assign word_take = (rem <= 4'(SR_BYTES - 4));                // room for a whole word
    assign load      = word_valid && word_take;

    assign lanes_data  = sr_q[31:0];
    // 4'd1 << 4 wraps to zero and gives all four lanes
    assign lanes_write = beat ? ((4'd1 << out_n) - 4'd1) : 4'd0;

    always_comb
    begin
        sr_d  = sr_q >> (8 * leaving);
        cnt_d = rem;
        if (load)
        begin
            for (int j = 0; j < 4; j++)
            begin
                if (j < int'(word.nbytes))
                    sr_d[8 * (rem + j) +: 8] = word.data[8 * j +: 8];   // append behind kept bytes
            end
            cnt_d = rem + 4'(word.nbytes);
        end
    end

    always_ff @(posedge clk)
    begin
        sr_q <= sr_d;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt_q <= '0;
        else
            cnt_q <= cnt_d;
    end

    // the serializer never offers an empty or oversized word
    a_nbytes_range: assert property (@(posedge clk) disable iff (!rst_n)
        word_valid |-> word.nbytes inside {[3'd1:3'd4]});

endmodule

`default_nettype wire

//--- hdl/packet_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module packet_assembler (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 streaming_enable,
    input  wire [2:0]           lanes_number,
    input  wire dsi_pkg::video_timing_t timing,
    input  wire [31:0]          pix_data,
    input  wire                 pix_empty,
    output wire                 pix_read,
    output wire [31:0]          lanes_data,
    output wire [3:0]           lanes_write,
    input  wire [3:0]           lanes_full
);

    logic                 hdr_write;
    logic                 hdr_full;
    logic                 hdr_read;
    logic                 hdr_empty;
    dsi_pkg::dsi_header_u hdr_in;
    dsi_pkg::dsi_header_u hdr_out;
    logic                 word_valid;
    logic                 word_take;
    dsi_pkg::lane_word_t  word;

    frame_sequencer seq_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .streaming_enable (streaming_enable),
        .timing           (timing),
        .hdr_full         (hdr_full),
        .hdr_write        (hdr_write),
        .hdr_in           (hdr_in)
    );

    header_queue queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr_write (hdr_write),
        .hdr_in    (hdr_in),
        .hdr_read  (hdr_read),
        .hdr_out   (hdr_out),
        .hdr_full  (hdr_full),
        .hdr_empty (hdr_empty)
    );

    packet_serializer ser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_out    (hdr_out),
        .hdr_empty  (hdr_empty),
        .hdr_read   (hdr_read),
        .pix_data   (pix_data),
        .pix_empty  (pix_empty),
        .pix_read   (pix_read),
        .word_take  (word_take),
        .word_valid (word_valid),
        .word       (word)
    );

    lane_packer pack_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lanes_number (lanes_number),
        .word_valid   (word_valid),
        .word         (word),
        .word_take    (word_take),
        .lanes_full   (lanes_full),
        .lanes_data   (lanes_data),
        .lanes_write  (lanes_write)
    );

endmodule

`default_nettype wire

//--- testbench/tb_packet_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsi_macros.svh"

module tb_packet_assembler;

    localparam int QUIET = 20;                                   // idle cycles after each phase

    logic                   clk;
    logic                   rst_n;
    logic                   streaming_enable;
    logic [2:0]             lanes_number;
    dsi_pkg::video_timing_t timing;
    logic [31:0]            pix_data;
    logic                   pix_empty;
    logic                   pix_read;
    logic [31:0]            lanes_data;
    logic [3:0]             lanes_write;
    logic [3:0]             lanes_full;

    integer                 seed = 75;
    logic                   bp_on = 1'b0;                        // back-pressure phase
    logic [7:0]             pix_cnt = 8'h00;                     // next byte of the pixel model
    logic [7:0]             pix_exp = 8'h00;                     // next pixel byte expected
    logic [7:0]             byte_q [$];                          // stream rebuilt from the lanes
    dsi_pkg::dsi_header_u   exp_q [$];
    int                     vss_seen = 0;
    int                     pkt_count = 0;
    int                     errors = 0;
    int                     cycles = 0;
    int                     limit = 0;

    packet_assembler dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .streaming_enable (streaming_enable),
        .lanes_number     (lanes_number),
        .timing           (timing),
        .pix_data         (pix_data),
        .pix_empty        (pix_empty),
        .pix_read         (pix_read),
        .lanes_data       (lanes_data),
        .lanes_write      (lanes_write),
        .lanes_full       (lanes_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic mismatch_error(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errors++;
        $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    endtask

    task automatic plain_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    // DSI Hamming parity equations over header bits D0..D23
    function automatic logic [7:0] hamming_ecc(input logic [23:0] d);
        logic [7:0] p;
        p    = 8'h00;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
             ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
             ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
             ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
             ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // one payload byte into the reflected CRC-16
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'h00, b};
        for (int k = 0; k < 8; k++)
            c = c[0] ? ((c >> 1) ^ `DSI_CRC_POLY) : (c >> 1);
        return c;
    endfunction

    function automatic int frame_bytes(input dsi_pkg::video_timing_t t);
        int blank_lines;
        int active_len;
        blank_lines = 1 + int'(t.vbp_lines) + int'(t.vfp_lines);
        // HSS plus three long packets of 6 overhead bytes each
        active_len  = 4 + 3 * 6 + int'(t.hbp_bytes) + int'(t.pixels) * 3 + int'(t.hfp_bytes);
        return blank_lines * int'(t.line_bytes) + int'(t.active_lines) * active_len;
    endfunction

    task automatic push_header(input logic [5:0] dt, input logic [15:0] wc);
        dsi_pkg::dsi_header_u h;
        h                         = '0;
        h.long_view.data_id.dt    = dt;
        h.long_view.word_count    = wc;                         // zero for short packets
        exp_q.push_back(h);
    endtask

    task automatic add_frame();
        logic [15:0] blank_wc;
        blank_wc = timing.line_bytes - 16'd10;
        push_header(`DSI_DT_VSS, 16'd0);
        push_header(`DSI_DT_BLANKING, blank_wc);
        for (int i = 0; i < int'(timing.vbp_lines); i++)
        begin
            push_header(`DSI_DT_HSS, 16'd0);
            push_header(`DSI_DT_BLANKING, blank_wc);
        end
        for (int i = 0; i < int'(timing.active_lines); i++)
        begin
            push_header(`DSI_DT_HSS, 16'd0);
            push_header(`DSI_DT_BLANKING, timing.hbp_bytes);
            push_header(`DSI_DT_PPS24, timing.pixels * 16'd3);
            push_header(`DSI_DT_BLANKING, timing.hfp_bytes);
        end
        for (int i = 0; i < int'(timing.vfp_lines); i++)
        begin
            push_header(`DSI_DT_HSS, 16'd0);
            push_header(`DSI_DT_BLANKING, blank_wc);
        end
    endtask

    // checks every complete packet at the head of the rebuilt stream
    task automatic parse_stream();
        dsi_pkg::dsi_header_u rx_hdr;
        dsi_pkg::dsi_header_u exp_hdr;
        logic [5:0]           dt;
        logic                 is_long;
        int                   wc;
        int                   need;
        int                   bad_idx;
        logic [7:0]           bad_exp;
        logic [7:0]           bad_got;
        logic [7:0]           want;
        logic [15:0]          crc;
        logic [15:0]          rx_crc;
        while (byte_q.size() >= 4)
        begin
            rx_hdr  = {byte_q[2], byte_q[1], byte_q[0]};
            dt      = rx_hdr.long_view.data_id.dt;
            is_long = (dt == `DSI_DT_BLANKING) || (dt == `DSI_DT_PPS24);
            wc      = is_long ? int'(rx_hdr.long_view.word_count) : 0;
            need    = is_long ? 4 + wc + 2 : 4;
            if (byte_q.size() < need)
                break;                                           // packet not complete yet
            pkt_count++;
            assert (exp_q.size() != 0)
                else plain_failure($sformatf("packet of type 0x%0h after the stream should stop",
                                             dt));
            if (exp_q.size() != 0)
            begin
                exp_hdr = exp_q.pop_front();
                assert (rx_hdr == exp_hdr) else mismatch_error("packet header", exp_hdr, rx_hdr);
            end
            assert (byte_q[3] == hamming_ecc(rx_hdr))
                else mismatch_error("header ECC", hamming_ecc(rx_hdr), byte_q[3]);
            if (dt == `DSI_DT_VSS)
                vss_seen++;
            if (is_long)
            begin
                bad_idx = -1;
                bad_exp = 8'h00;
                bad_got = 8'h00;
                crc     = `DSI_CRC_INIT;
                for (int k = 0; k < wc; k++)
                begin
                    want = (dt == `DSI_DT_PPS24) ? pix_exp + 8'(k) : `DSI_BLANK_BYTE;
                    crc  = crc_step(crc, byte_q[4 + k]);
                    if (bad_idx < 0 && byte_q[4 + k] != want)
                    begin
                        bad_idx = k;
                        bad_exp = want;
                        bad_got = byte_q[4 + k];
                    end
                end
                assert (bad_idx < 0)
                    else mismatch_error($sformatf("payload byte %0d", bad_idx), bad_exp, bad_got);
                rx_crc = {byte_q[need - 1], byte_q[need - 2]};  // low byte first
                assert (rx_crc == crc) else mismatch_error("packet CRC", crc, rx_crc);
                if (dt == `DSI_DT_PPS24)
                    pix_exp = pix_exp + 8'((wc + 3) / 4 * 4);    // whole pixel words consumed
            end
            repeat (need) void'(byte_q.pop_front());
        end
    endtask

    // lane monitor and pixel model sampled on the rising edge
    always @(posedge clk)
    begin
        if (!streaming_enable && exp_q.size() == 0)
        begin
            assert (lanes_write == 4'b0000) else mismatch_error("lanes_write", 0, lanes_write);
            assert (pix_read == 1'b0) else mismatch_error("pix_read", 0, pix_read);
        end
        if (|lanes_full)
            assert (lanes_write == 4'b0000) else mismatch_error("lanes_write", 0, lanes_write);
        assert (lanes_write inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
            else plain_failure("lanes_write is not contiguous from lane 0");
        assert ($countones(lanes_write) <= int'(lanes_number))
            else plain_failure("lanes_write has more bits set than lanes_number");
        if (pix_read)
            pix_cnt = pix_cnt + 8'd4;
        for (int i = 0; i < 4; i++)
        begin
            if (lanes_write[i])
                byte_q.push_back(lanes_data[8 * i +: 8]);
        end
        parse_stream();
    end

    always @(negedge clk)
    begin : drive_sources
        logic [31:0] r;
        r        = $random(seed);
        pix_data = {pix_cnt + 8'd3, pix_cnt + 8'd2, pix_cnt + 8'd1, pix_cnt};
        if (bp_on)
        begin
            lanes_full = (r[1:0] == 2'd0) ? r[7:4] : 4'b0000;
            pix_empty  = (r[9:8] == 2'd0);                       // gaps in the pixel source
        end
        else
        begin
            lanes_full = 4'b0000;
            pix_empty  = 1'b0;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout after %0d cycles, %0d packets checked, %0d errors",
                     limit, pkt_count, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic run_frames(input int frames, input logic [2:0] lanes, input logic pressure);
        int vss_target;
        lanes_number = lanes;                                    // assembler is idle here
        bp_on       <= pressure;
        for (int f = 0; f < frames; f++)
            add_frame();
        vss_target       = vss_seen + frames;
        streaming_enable = 1'b1;
        while (vss_seen < vss_target)
            @(negedge clk);
        streaming_enable = 1'b0;                                 // frame in flight completes
        while (exp_q.size() != 0)
            @(negedge clk);
        bp_on <= 1'b0;
        repeat (QUIET) @(negedge clk);
        assert (byte_q.size() == 0)
            else plain_failure("stream bytes left over after the last expected packet");
    endtask

    initial
    begin
        rst_n            = 1'b0;
        streaming_enable = 1'b0;
        lanes_number     = 3'd4;
        pix_data         = 32'h0;
        pix_empty        = 1'b0;
        lanes_full       = 4'b0000;
        timing           = '{line_bytes: 16'd40, hbp_bytes: 16'd4, hfp_bytes: 16'd6,
                             pixels: 16'd6, vbp_lines: 16'd1, active_lines: 16'd2,
                             vfp_lines: 16'd1};
        // 2 frames on 4 lanes, 1 on 2 lanes, 1 on 1 lane, plus idle windows
        limit = (2 * frame_bytes(timing) / 4 + frame_bytes(timing) / 2
                 + frame_bytes(timing)) * 4 + 4 * QUIET + 200;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (QUIET) @(negedge clk);                           // idle with streaming off
        run_frames(2, 3'd4, 1'b0);
        run_frames(1, 3'd2, 1'b1);
        run_frames(1, 3'd1, 1'b0);
        $display("packets checked: %0d, errors: %0d", pkt_count, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/dsi_pkg.sv
hdl/packet_ecc.sv
hdl/packet_crc.sv
hdl/frame_sequencer.sv
hdl/header_queue.sv
hdl/packet_serializer.sv
hdl/lane_packer.sv
hdl/packet_assembler.sv
testbench/tb_packet_assembler.sv

//--- Bender.yml
package:
  name: packet_assembler

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dsi_pkg.sv
      - hdl/packet_ecc.sv
      - hdl/packet_crc.sv
      - hdl/frame_sequencer.sv
      - hdl/header_queue.sv
      - hdl/packet_serializer.sv
      - hdl/lane_packer.sv
      - hdl/packet_assembler.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_packet_assembler.sv
